// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_atg_static_wr
FILELIST  := atg_static_wr_top.f

BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== atg_static_wr_top.f ====
+incdir+include
src/atg_pkg.sv
src/atg_cfg_if.sv
src/atg_ctrl_regs.sv
src/atg_aw_gen.sv
src/atg_w_gen.sv
src/atg_static_wr_top.sv
verif/axi_wr_slave_model.sv
verif/tb_atg_static_wr.sv

// ==== include/atg_params.svh ====
`ifndef ATG_PARAMS_SVH
`define ATG_PARAMS_SVH

// Address window of the write traffic
`define ATG_WR_ADDRESS      32'h0000_0000
`define ATG_WR_HIGH_ADDRESS 32'h0000_17FF

// Bursts allowed in flight before a response must return, at most 7
`define ATG_WR_PIPELINE     4

// Minimum cycles from one address launch to the next
`define ATG_TRANGAP         32'd3

// Burst length in beats after reset
`define ATG_DEFAULT_LENGTH  8'd16

// A burst never crosses one of these
`define ATG_PAGE_BYTES      32'd4096

// Four bytes per beat on the 32 bit data bus
`define ATG_BEAT_SHIFT      2

`endif

// ==== src/atg_aw_gen.sv ====
`timescale 1ns/1ps
`include "atg_params.svh"

module atg_aw_gen (
  input  logic                Clk,
  input  logic                rst_l,
  atg_cfg_if.aw               cfg,
  input  logic                awready_m,
  input  logic                bvalid_m,
  output atg_pkg::addr_t      awaddr_m,
  output atg_pkg::len_t       awlen_m,
  output logic                awvalid_m,
  output logic                bready_m
);

  // One past the last usable byte in 33 bits so it cannot wrap
  localparam logic [32:0] high_end = {1'b0, `ATG_WR_HIGH_ADDRESS} + 33'd1;

  logic           aw_xfer;
  logic           b_xfer;
  logic           gap_done;
  logic           room;
  logic           issue;
  logic [31:0]    gap_cnt;
  atg_pkg::pipe_t outstanding;
  atg_pkg::addr_t page_limit;
  atg_pkg::addr_t step;
  atg_pkg::addr_t cand;
  logic [32:0]    cand_end;

  assign aw_xfer = awvalid_m & awready_m;
  assign b_xfer  = bvalid_m & bready_m;

  assign gap_done = (gap_cnt == `ATG_TRANGAP);

  // The address accepted this cycle is not in outstanding yet
  assign room = ({1'b0, outstanding} + {3'b000, aw_xfer}) < 4'(`ATG_WR_PIPELINE);

  // New address only once the bus slot is free
  assign issue = cfg.start |
                 (cfg.enabled & gap_done & room & (~awvalid_m | aw_xfer));

  // Bytes covered by one burst
  assign step     = (atg_pkg::addr_t'(cfg.burst_len) + 32'd1) << `ATG_BEAT_SHIFT;
  assign cand     = awaddr_m + step;
  assign cand_end = {1'b0, cand} + {1'b0, step};

  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      awvalid_m <= 1'b0;
    end else if (issue) begin
      awvalid_m <= 1'b1;
    end else if (aw_xfer) begin
      awvalid_m <= 1'b0;
    end
  end

  // Address stepping with high and page wrap
  always_ff @(posedge Clk) begin
    if (cfg.start) begin
      awaddr_m   <= `ATG_WR_ADDRESS;
      page_limit <= `ATG_WR_ADDRESS + `ATG_PAGE_BYTES;
      awlen_m    <= cfg.burst_len;
    end else if (issue) begin
      awlen_m <= cfg.burst_len;
      if (cand_end > high_end) begin
        awaddr_m   <= `ATG_WR_ADDRESS;
        page_limit <= `ATG_WR_ADDRESS + `ATG_PAGE_BYTES;
      end else if (cand_end > {1'b0, page_limit}) begin
        awaddr_m   <= page_limit;
        page_limit <= page_limit + `ATG_PAGE_BYTES;
      end else begin
        awaddr_m <= cand;
      end
    end
  end

  // Pulses in the first cycle a new address is on the bus
  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      cfg.launch <= 1'b0;
    end else begin
      cfg.launch <= issue;
    end
  end

  // Launch spacing counter saturates at the gap value
  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      gap_cnt <= `ATG_TRANGAP;
    end else if (issue) begin
      gap_cnt <= '0;
    end else if (!gap_done) begin
      gap_cnt <= gap_cnt + 32'd1;
    end
  end

  // Accepted addresses still waiting for a response
  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      outstanding <= '0;
    end else begin
      case ({aw_xfer, b_xfer})
        2'b10:   outstanding <= outstanding + 3'd1;
        2'b01:   outstanding <= outstanding - 3'd1;
        default: outstanding <= outstanding;
      endcase
    end
  end

  // Responses are always taken from the first address on
  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      bready_m <= 1'b0;
    end else if (issue) begin
      bready_m <= 1'b1;
    end
  end

  assign cfg.aw_idle = ~awvalid_m & (outstanding == '0);

endmodule

// ==== src/atg_cfg_if.sv ====
`timescale 1ns/1ps

interface atg_cfg_if;

  // Run control from the register block
  logic             start;
  logic             enabled;
  logic             stop;
  atg_pkg::len_t    burst_len;

  // Address side status
  logic             launch;
  logic             aw_idle;

  // Data side status
  logic             w_idle;
  logic             burst_written;

  modport ctrl (
    output start,
    output enabled,
    output stop,
    output burst_len,
    input  aw_idle,
    input  w_idle,
    input  burst_written
  );

  modport aw (
    input  start,
    input  enabled,
    input  burst_len,
    output launch,
    output aw_idle
  );

  // Data side only needs to know when a burst was put on AW
  modport w (
    input  launch,
    input  burst_len,
    output w_idle,
    output burst_written
  );

endinterface

// ==== src/atg_ctrl_regs.sv ====
`timescale 1ns/1ps
`include "atg_params.svh"

module atg_ctrl_regs (
  input  logic                Clk,
  input  logic                rst_l,
  input  logic                reg1_st_enable,
  input  logic                reset_reg1_done,
  input  atg_pkg::len_t       reg2_length,
  input  logic                reg2_length_req,
  atg_cfg_if.ctrl             cfg,
  output logic                reg1_done,
  output atg_pkg::cnt_t       reg4_wrcnt
);

  logic en_q1;
  logic en_q2;
  logic en_rise;
  logic en_fall;

  // Two stage sync of the enable level
  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      en_q1 <= 1'b0;
      en_q2 <= 1'b0;
    end else begin
      en_q1 <= reg1_st_enable;
      en_q2 <= en_q1;
    end
  end

  assign en_rise = en_q1 & ~en_q2;
  assign en_fall = ~en_q1 & en_q2;

  assign cfg.enabled = en_q2;

  // Start is registered so it lines up with the enabled level
  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      cfg.start <= 1'b0;
    end else begin
      cfg.start <= en_rise;
    end
  end

  // Stop level, held until the next run or a done clear
  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      cfg.stop <= 1'b0;
    end else if (cfg.start || reset_reg1_done) begin
      cfg.stop <= 1'b0;
    end else if (en_fall) begin
      cfg.stop <= 1'b1;
    end
  end

  // Length register, value is beats minus one
  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      cfg.burst_len <= `ATG_DEFAULT_LENGTH - 8'd1;
    end else if (reg2_length_req) begin
      cfg.burst_len <= reg2_length;
    end
  end

  // Done once stopped and both channels have drained
  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      reg1_done <= 1'b0;
    end else if (cfg.start || reset_reg1_done) begin
      reg1_done <= 1'b0;
    end else if (cfg.stop && cfg.aw_idle && cfg.w_idle) begin
      reg1_done <= 1'b1;
    end
  end

  // Bursts whose last beat went out in this run
  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      reg4_wrcnt <= '0;
    end else if (cfg.start) begin
      reg4_wrcnt <= '0;
    end else if (cfg.burst_written) begin
      reg4_wrcnt <= reg4_wrcnt + 32'd1;
    end
  end

endmodule

// ==== src/atg_pkg.sv ====
package atg_pkg;

  // Byte address on the AW channel
  typedef logic [31:0] addr_t;

  // One beat of write data
  typedef logic [31:0] data_t;

  // AXI length field, beats minus one
  typedef logic [7:0] len_t;

  // Completed burst count
  typedef logic [31:0] cnt_t;

  // Bursts outstanding or waiting for data
  typedef logic [2:0] pipe_t;

endpackage

// ==== src/atg_static_wr_top.sv ====
`timescale 1ns/1ps

module atg_static_wr_top (
  input  logic                Clk,
  input  logic                rst_l,

  // Control and status registers
  input  logic                reg1_st_enable,
  input  logic                reset_reg1_done,
  input  atg_pkg::len_t       reg2_length,
  input  logic                reg2_length_req,
  output logic                reg1_done,
  output atg_pkg::cnt_t       reg4_wrcnt,

  // AXI write address channel
  output atg_pkg::addr_t      awaddr_m,
  output atg_pkg::len_t       awlen_m,
  output logic                awvalid_m,
  input  logic                awready_m,

  // AXI write data channel
  output atg_pkg::data_t      wdata_m,
  output logic                wvalid_m,
  output logic                wlast_m,
  input  logic                wready_m,

  // AXI write response channel
  input  logic                bvalid_m,
  output logic                bready_m
);

  atg_cfg_if cfg ();

  atg_ctrl_regs i_atg_ctrl_regs (
    .Clk             (Clk),
    .rst_l           (rst_l),
    .reg1_st_enable  (reg1_st_enable),
    .reset_reg1_done (reset_reg1_done),
    .reg2_length     (reg2_length),
    .reg2_length_req (reg2_length_req),
    .cfg             (cfg.ctrl),
    .reg1_done       (reg1_done),
    .reg4_wrcnt      (reg4_wrcnt)
  );

  atg_aw_gen i_atg_aw_gen (
    .Clk       (Clk),
    .rst_l     (rst_l),
    .cfg       (cfg.aw),
    .awready_m (awready_m),
    .bvalid_m  (bvalid_m),
    .awaddr_m  (awaddr_m),
    .awlen_m   (awlen_m),
    .awvalid_m (awvalid_m),
    .bready_m  (bready_m)
  );

  atg_w_gen i_atg_w_gen (
    .Clk      (Clk),
    .rst_l    (rst_l),
    .cfg      (cfg.w),
    .wready_m (wready_m),
    .wdata_m  (wdata_m),
    .wvalid_m (wvalid_m),
    .wlast_m  (wlast_m)
  );

endmodule

// ==== src/atg_w_gen.sv ====
`timescale 1ns/1ps

module atg_w_gen (
  input  logic                Clk,
  input  logic                rst_l,
  atg_cfg_if.w                cfg,
  input  logic                wready_m,
  output atg_pkg::data_t      wdata_m,
  output logic                wvalid_m,
  output logic                wlast_m
);

  // Beat data, indexed by beat number modulo 16
  localparam atg_pkg::data_t test_pattern [16] = '{
    32'h12A0_A51F, 32'hCAFE_5AFE, 32'hC001_A51F, 32'hC001_CA5E,
    32'hC001_12AF, 32'h5AFE_5AFE, 32'hA51F_A51F, 32'h5AFE_CAFE,
    32'h12A0_12A0, 32'hCAFE_C001, 32'hA51F_12A0, 32'hC001_CAFE,
    32'hCAA1_A51F, 32'hCAFE_A51F, 32'hCAA1_12A0, 32'hC001_5AFE
  };

  logic           w_xfer;
  logic           burst_start;
  atg_pkg::pipe_t queued;
  atg_pkg::len_t  beat_cnt;
  atg_pkg::len_t  next_beat;

  assign w_xfer            = wvalid_m & wready_m;
  assign cfg.burst_written = w_xfer & wlast_m;
  assign next_beat         = beat_cnt + 8'd1;

  // A gap cycle always follows the last beat, so wvalid low means free
  assign burst_start = ~wvalid_m & (queued != '0);

  // Bursts launched on AW whose data is not yet complete
  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      queued <= '0;
    end else begin
      case ({cfg.launch, cfg.burst_written})
        2'b10:   queued <= queued + 3'd1;
        2'b01:   queued <= queued - 3'd1;
        default: queued <= queued;
      endcase
    end
  end

  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      wvalid_m <= 1'b0;
      wlast_m  <= 1'b0;
      beat_cnt <= '0;
    end else if (cfg.burst_written) begin
      wvalid_m <= 1'b0;
      wlast_m  <= 1'b0;
      beat_cnt <= '0;
    end else if (burst_start) begin
      wvalid_m <= 1'b1;
      wlast_m  <= (cfg.burst_len == '0);
      beat_cnt <= '0;
    end else if (w_xfer) begin
      beat_cnt <= next_beat;
      wlast_m  <= (next_beat == cfg.burst_len);
    end
  end

  always_ff @(posedge Clk) begin
    if (burst_start) begin
      wdata_m <= test_pattern[0];
    end else if (w_xfer && !wlast_m) begin
      wdata_m <= test_pattern[next_beat[3:0]];
    end
  end

  assign cfg.w_idle = ~wvalid_m & (queued == '0);

endmodule

// ==== verif/axi_wr_slave_model.sv ====
`timescale 1ns/1ps

module axi_wr_slave_model #(
  parameter int SEED = 83174
) (
  input  logic Clk,
  input  logic rst_l,
  input  logic awvalid_m,
  output logic awready_m,
  input  logic wvalid_m,
  input  logic wlast_m,
  output logic wready_m,
  output logic bvalid_m,
  input  logic bready_m
);

  integer seed;
  int     aw_taken;
  int     w_done;
  int     b_raised;
  int     b_taken;
  int     delay;

  initial begin
    seed      = SEED;
    awready_m = 1'b0;
    wready_m  = 1'b0;
    bvalid_m  = 1'b0;
  end

  // Handshakes seen on each channel
  always @(posedge Clk) begin
    if (rst_l) begin
      if (awvalid_m && awready_m) aw_taken++;
      if (wvalid_m && wready_m && wlast_m) w_done++;
      if (bvalid_m && bready_m) b_taken++;
    end
  end

  always @(negedge Clk) begin
    if (rst_l) begin
      awready_m = ($random(seed) & 3) != 0;
      wready_m  = ($random(seed) & 3) != 0;
      // Drop the response once it was taken
      if (bvalid_m && b_taken == b_raised) bvalid_m = 1'b0;
      // A burst is answered only after both its address and last beat
      if (!bvalid_m && b_raised < aw_taken && b_raised < w_done) begin
        if (delay == 0) begin
          bvalid_m = 1'b1;
          b_raised++;
          delay    = $random(seed) & 7;
        end else begin
          delay--;
        end
      end
    end
  end

endmodule

// ==== verif/tb_atg_static_wr.sv ====
`timescale 1ns/1ps
`include "atg_params.svh"

module tb_atg_static_wr;

  localparam int RUN_CYCLES  = 400;
  localparam int NUM_RUNS    = 2;
  localparam int CYCLE_LIMIT = 2 * (NUM_RUNS * RUN_CYCLES + 3) + 2000;
  localparam int GAP         = `ATG_TRANGAP;
  localparam int PIPE        = `ATG_WR_PIPELINE;

  // Beat data expected by beat index modulo 16
  localparam atg_pkg::data_t pattern [16] = '{
    32'h12A0_A51F, 32'hCAFE_5AFE, 32'hC001_A51F, 32'hC001_CA5E,
    32'hC001_12AF, 32'h5AFE_5AFE, 32'hA51F_A51F, 32'h5AFE_CAFE,
    32'h12A0_12A0, 32'hCAFE_C001, 32'hA51F_12A0, 32'hC001_CAFE,
    32'hCAA1_A51F, 32'hCAFE_A51F, 32'hCAA1_12A0, 32'hC001_5AFE
  };

  logic           Clk, rst_l;
  logic           reg1_st_enable, reset_reg1_done, reg2_length_req;
  atg_pkg::len_t  reg2_length, awlen_m;
  logic           awready_m, wready_m, bvalid_m;
  logic           awvalid_m, wvalid_m, wlast_m, bready_m, reg1_done;
  atg_pkg::addr_t awaddr_m;
  atg_pkg::data_t wdata_m;
  atg_pkg::cnt_t  reg4_wrcnt;

  // Reference model state
  integer         seed;
  int             run_id, seen_run, cycle_cnt, last_launch;
  int             aw_cnt, b_cnt, w_bursts, mismatch_cnt, fail_cnt;
  atg_pkg::len_t  run_len, beat;
  atg_pkg::addr_t exp_addr, page_limit;
  atg_pkg::cnt_t  wr_model;
  logic           new_run, prev_awvalid, prev_aw_xfer, prev_done, prev_clear, aw_seen;

  atg_static_wr_top i_atg_static_wr_top (.*);

  axi_wr_slave_model #(.SEED(83174)) i_axi_wr_slave_model (.*);

  initial Clk = 1'b0;
  always #50 Clk = ~Clk;

  task automatic show_mismatch(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    mismatch_cnt++;
    $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
  endtask

  task automatic show_failure(input string what);
    fail_cnt++;
    $display("Error at %0t: %s", $time, what);
  endtask

  // Next burst address stays inside the window and off page crossings
  task automatic step_address;
    atg_pkg::addr_t step;
    atg_pkg::addr_t cand;
    logic [32:0]    burst_end;
    step      = (32'(run_len) + 32'd1) << `ATG_BEAT_SHIFT;
    cand      = exp_addr + step;
    burst_end = {1'b0, cand} + {1'b0, step} - 33'd1;
    if (burst_end > {1'b0, `ATG_WR_HIGH_ADDRESS}) begin
      exp_addr   = `ATG_WR_ADDRESS;
      page_limit = `ATG_WR_ADDRESS + `ATG_PAGE_BYTES;
    end else if (burst_end >= {1'b0, page_limit}) begin
      exp_addr   = page_limit;
      page_limit = page_limit + `ATG_PAGE_BYTES;
    end else begin
      exp_addr = cand;
    end
  endtask

  always @(posedge Clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles without finishing the runs", cycle_cnt);
      $display("Test failed");
      $finish;
    end else if (!rst_l) begin
      seen_run     = 0;
      prev_awvalid = 1'b0;
      prev_aw_xfer = 1'b0;
      prev_done    = 1'b0;
      prev_clear   = 1'b0;
      aw_seen      = 1'b0;
      wr_model     = '0;
      beat         = '0;
    end else begin
      // First address of a new run restarts the model
      new_run = (run_id != seen_run) && awvalid_m;
      if (new_run) begin
        seen_run    = run_id;
        wr_model    = '0;
        beat        = '0;
        exp_addr    = `ATG_WR_ADDRESS;
        page_limit  = `ATG_WR_ADDRESS + `ATG_PAGE_BYTES;
        last_launch = cycle_cnt - GAP;
      end
      if (reg4_wrcnt !== wr_model) show_mismatch("reg4_wrcnt", wr_model, reg4_wrcnt);
      // Response ready comes up with the first address and stays up
      if (bready_m !== (aw_seen || awvalid_m))
        show_mismatch("bready_m", 32'(aw_seen || awvalid_m), 32'(bready_m));
      aw_seen = aw_seen || awvalid_m;
      if (awvalid_m && (!prev_awvalid || prev_aw_xfer)) begin
        if (cycle_cnt - last_launch < GAP) show_failure("address launches too close");
        last_launch = cycle_cnt;
      end
      if (awvalid_m && awready_m) begin
        if (awaddr_m !== exp_addr) show_mismatch("awaddr_m", exp_addr, awaddr_m);
        if (awlen_m !== run_len) show_mismatch("awlen_m", 32'(run_len), 32'(awlen_m));
        step_address();
        aw_cnt++;
      end
      if (wvalid_m && wready_m) begin
        if (wdata_m !== pattern[beat[3:0]]) show_mismatch("wdata_m", pattern[beat[3:0]], wdata_m);
        if (wlast_m !== (beat == run_len))
          show_mismatch("wlast_m", 32'(beat == run_len), 32'(wlast_m));
        beat = wlast_m ? 8'd0 : beat + 8'd1;
        if (wlast_m) begin
          wr_model = wr_model + 32'd1;
          w_bursts++;
        end
      end
      if (bvalid_m && bready_m) b_cnt++;
      if (aw_cnt - b_cnt > PIPE) show_failure("too many bursts outstanding");
      if (reg1_done && !prev_done) begin
        if (reg1_st_enable || awvalid_m || wvalid_m || aw_cnt != b_cnt)
          show_failure("reg1_done rose before all bursts were answered");
        if (w_bursts != aw_cnt)
          show_failure("data bursts do not match address bursts at done");
      end
      if (prev_done && !reg1_done && !prev_clear && !new_run)
        show_failure("reg1_done fell without a clear");
      if (prev_clear && reg1_done) show_failure("reg1_done still high after reset_reg1_done");
      prev_awvalid = awvalid_m;
      prev_aw_xfer = awvalid_m && awready_m;
      prev_done    = reg1_done;
      prev_clear   = reset_reg1_done;
    end
  end

  // Load a random length, run with enable high, then wait for done
  task automatic run_traffic;
    @(negedge Clk);
    reg2_length     = atg_pkg::len_t'($random(seed) & 15);
    reg2_length_req = 1'b1;
    run_len         = reg2_length;
    @(negedge Clk);
    reg2_length_req = 1'b0;
    run_id          = run_id + 1;
    reg1_st_enable  = 1'b1;
    repeat (RUN_CYCLES) @(negedge Clk);
    reg1_st_enable = 1'b0;
    while (reg1_done !== 1'b1) @(negedge Clk);
    repeat (5) @(negedge Clk);
  endtask

  initial begin
    seed            = 83174;
    run_id          = 0;
    run_len         = `ATG_DEFAULT_LENGTH - 8'd1;
    rst_l           = 1'b0;
    reg1_st_enable  = 1'b0;
    reset_reg1_done = 1'b0;
    reg2_length     = '0;
    reg2_length_req = 1'b0;
    repeat (3) @(negedge Clk);
    rst_l = 1'b1;
    run_traffic();
    reset_reg1_done = 1'b1;
    @(negedge Clk);
    reset_reg1_done = 1'b0;
    repeat (4) @(negedge Clk);
    run_traffic();
    if (aw_cnt == 0 || aw_cnt != b_cnt)
      $display("Traffic incomplete with %0d bursts and %0d responses", aw_cnt, b_cnt);
    $display("Errors: %0d mismatches, %0d other failures over %0d bursts",
             mismatch_cnt, fail_cnt, aw_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0 && aw_cnt > 0 && aw_cnt == b_cnt) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
